// File: design/ctrl_settings.svh
`ifndef CTRL_SETTINGS_SVH
`define CTRL_SETTINGS_SVH

// instruction word width
`define INST_WIDTH 32

// register file address width, x0 to x31
`define REG_ADDR_WIDTH 5

// privilege level width
`define PRV_WIDTH 2

`endif

// File: design/ctrl_pkg.sv
`include "ctrl_settings.svh"

package ctrl_pkg;

	// rv32 major opcodes
	typedef enum logic [6:0] {
		OPC_LOAD     = 7'b0000011,
		OPC_STORE    = 7'b0100011,
		OPC_BRANCH   = 7'b1100011,
		OPC_JAL      = 7'b1101111,
		OPC_JALR     = 7'b1100111,
		OPC_MISC_MEM = 7'b0001111,
		OPC_OP_IMM   = 7'b0010011,
		OPC_OP       = 7'b0110011,
		OPC_SYSTEM   = 7'b1110011,
		OPC_AUIPC    = 7'b0010111,
		OPC_LUI      = 7'b0110111
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SLL  = 4'd1,
		ALU_XOR  = 4'd4,
		ALU_SRL  = 4'd5,
		ALU_OR   = 4'd6,
		ALU_AND  = 4'd7,
		ALU_SEQ  = 4'd8,
		ALU_SNE  = 4'd9,
		ALU_SUB  = 4'd10,
		ALU_SRA  = 4'd11,
		ALU_SLT  = 4'd12,
		ALU_SGE  = 4'd13,
		ALU_SLTU = 4'd14,
		ALU_SGEU = 4'd15
	} alu_op_e;

	typedef enum logic [2:0] {
		PC_PLUS_FOUR, PC_BRANCH_TARGET, PC_JAL_TARGET, PC_JALR_TARGET,
		PC_REPLAY, PC_HANDLER, PC_EPC
	} pc_src_e;

	typedef enum logic [1:0] {IMM_I, IMM_S, IMM_U, IMM_J} imm_type_e;
	typedef enum logic [1:0] {SRC_A_RS1, SRC_A_PC, SRC_A_ZERO} src_a_e;
	typedef enum logic [1:0] {SRC_B_RS2, SRC_B_IMM, SRC_B_FOUR, SRC_B_ZERO} src_b_e;
	typedef enum logic [1:0] {WB_SRC_ALU, WB_SRC_MEM, WB_SRC_CSR, WB_SRC_MD} wb_src_e;

	// read is 4 so that bit 2 marks an active command
	typedef enum logic [2:0] {
		CSR_IDLE  = 3'd0,
		CSR_READ  = 3'd4,
		CSR_WRITE = 3'd5,
		CSR_SET   = 3'd6,
		CSR_CLEAR = 3'd7
	} csr_cmd_e;

	typedef enum logic [1:0] {MD_OP_MUL, MD_OP_DIV, MD_OP_REM} md_op_e;
	typedef enum logic [1:0] {MD_OUT_LO, MD_OUT_HI, MD_OUT_REM} md_out_e;

	// ecall codes 8 to 11 follow the privilege level
	typedef enum logic [3:0] {
		ECODE_INST_ADDR_MISALIGNED      = 4'd0,
		ECODE_ILLEGAL_INST              = 4'd2,
		ECODE_BREAKPOINT                = 4'd3,
		ECODE_LOAD_ADDR_MISALIGNED      = 4'd4,
		ECODE_STORE_AMO_ADDR_MISALIGNED = 4'd6,
		ECODE_ECALL_FROM_U              = 4'd8
	} ecode_e;

	typedef struct packed {
		imm_type_e imm_type;
		src_a_e    src_a_sel;
		src_b_e    src_b_sel;
		alu_op_e   alu_op;
		logic [2:0] dmem_size;
		logic [2:0] dmem_type;
		md_op_e    md_op;
		md_out_e   md_out_sel;
		logic      md_in_1_signed;
		logic      md_in_2_signed;
		logic      csr_imm_sel;
	} dpath_ctrl_t;

	// decode results before any kill
	typedef struct packed {
		logic branch_taken;
		logic jal;
		logic jalr;
		logic eret;
		logic dmem_en;
		logic dmem_wen;
		logic wr_reg;
		logic uses_md;
		logic fence_i;
		logic uses_rs1;
		logic uses_rs2;
		logic new_ex;
		ecode_e new_ex_code;
		csr_cmd_e csr_cmd;
		wb_src_e wb_src_sel;
		logic [`REG_ADDR_WIDTH-1:0] rs1_addr;
		logic [`REG_ADDR_WIDTH-1:0] rs2_addr;
		logic [`REG_ADDR_WIDTH-1:0] rd_addr;
	} dx_flags_t;

	typedef struct packed {
		logic wr_reg;
		logic [`REG_ADDR_WIDTH-1:0] reg_to_wr;
		logic load_in_wb;
		logic uses_md_wb;
	} wb_state_t;

	typedef struct packed {
		logic wr_reg;
		logic [`REG_ADDR_WIDTH-1:0] reg_to_wr;
		wb_src_e wb_src_sel;
	} wb_port_t;

	typedef struct packed {
		logic stall_if;
		logic kill_if;
		logic stall_dx;
		logic kill_dx;
		logic stall_wb;
		logic kill_wb;
	} stage_ctrl_t;

endpackage

// File: design/inst_decoder.sv
`include "ctrl_settings.svh"

module inst_decoder import ctrl_pkg::*; (
	input logic [`INST_WIDTH-1:0] inst_DX,
	input logic cmp_true,
	input logic [`PRV_WIDTH-1:0] prv,
	output dpath_ctrl_t dpath,
	output dx_flags_t flags
);

	opcode_e opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [11:0] funct12;
	logic [`REG_ADDR_WIDTH-1:0] rs1_addr;
	logic [`REG_ADDR_WIDTH-1:0] rd_addr;
	logic illegal;
	logic ecall;
	logic ebreak;
	alu_op_e alu_op_arith;

	assign opcode = opcode_e'(inst_DX[6:0]);
	assign funct3 = inst_DX[14:12];
	assign funct7 = inst_DX[31:25];
	assign funct12 = inst_DX[31:20];
	assign rs1_addr = inst_DX[19:15];
	assign rd_addr = inst_DX[11:7];

	// shared by OP and OP_IMM, sub only exists for register operands
	always_comb begin
		case (funct3)
			3'b000: alu_op_arith = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
			3'b001: alu_op_arith = ALU_SLL;
			3'b010: alu_op_arith = ALU_SLT;
			3'b011: alu_op_arith = ALU_SLTU;
			3'b100: alu_op_arith = ALU_XOR;
			3'b101: alu_op_arith = funct7[5] ? ALU_SRA : ALU_SRL;
			3'b110: alu_op_arith = ALU_OR;
			default: alu_op_arith = ALU_AND;
		endcase
	end

	always_comb begin
		illegal = 1'b0;
		ecall = 1'b0;
		ebreak = 1'b0;
		flags = '0;
		flags.uses_rs1 = 1'b1;
		flags.csr_cmd = CSR_IDLE;
		flags.wb_src_sel = WB_SRC_ALU;
		flags.new_ex_code = ECODE_ILLEGAL_INST;
		flags.rs1_addr = rs1_addr;
		flags.rs2_addr = inst_DX[24:20];
		flags.rd_addr = rd_addr;
		dpath.imm_type = IMM_I;
		dpath.src_a_sel = SRC_A_RS1;
		dpath.src_b_sel = SRC_B_IMM;
		dpath.alu_op = ALU_ADD;
		dpath.dmem_size = {1'b0, funct3[1:0]};
		dpath.dmem_type = funct3;
		dpath.csr_imm_sel = funct3[2];
		dpath.md_op = MD_OP_MUL;
		dpath.md_out_sel = MD_OUT_LO;
		dpath.md_in_1_signed = 1'b0;
		dpath.md_in_2_signed = 1'b0;

		// multiply/divide fields, only used when uses_md is set
		case (funct3)
			3'b001: begin
				dpath.md_in_1_signed = 1'b1;
				dpath.md_in_2_signed = 1'b1;
				dpath.md_out_sel = MD_OUT_HI;
			end
			3'b010: begin
				dpath.md_in_1_signed = 1'b1;
				dpath.md_out_sel = MD_OUT_HI;
			end
			3'b011: dpath.md_out_sel = MD_OUT_HI;
			3'b100: begin
				dpath.md_op = MD_OP_DIV;
				dpath.md_in_1_signed = 1'b1;
				dpath.md_in_2_signed = 1'b1;
			end
			3'b101: dpath.md_op = MD_OP_DIV;
			3'b110: begin
				dpath.md_op = MD_OP_REM;
				dpath.md_in_1_signed = 1'b1;
				dpath.md_in_2_signed = 1'b1;
				dpath.md_out_sel = MD_OUT_REM;
			end
			3'b111: begin
				dpath.md_op = MD_OP_REM;
				dpath.md_out_sel = MD_OUT_REM;
			end
			default: ;
		endcase

		case (opcode)
			OPC_LOAD: begin
				flags.dmem_en = 1'b1;
				flags.wr_reg = 1'b1;
				flags.wb_src_sel = WB_SRC_MEM;
			end
			OPC_STORE: begin
				flags.uses_rs2 = 1'b1;
				flags.dmem_en = 1'b1;
				flags.dmem_wen = 1'b1;
				dpath.imm_type = IMM_S;
			end
			OPC_BRANCH: begin
				flags.uses_rs2 = 1'b1;
				flags.branch_taken = cmp_true;
				dpath.src_b_sel = SRC_B_RS2;
				case (funct3)
					3'b000: dpath.alu_op = ALU_SEQ;
					3'b001: dpath.alu_op = ALU_SNE;
					3'b100: dpath.alu_op = ALU_SLT;
					3'b101: dpath.alu_op = ALU_SGE;
					3'b110: dpath.alu_op = ALU_SLTU;
					3'b111: dpath.alu_op = ALU_SGEU;
					default: illegal = 1'b1;
				endcase
			end
			OPC_JAL: begin
				flags.jal = 1'b1;
				flags.uses_rs1 = 1'b0;
				flags.wr_reg = 1'b1;
				dpath.src_a_sel = SRC_A_PC;
				dpath.src_b_sel = SRC_B_FOUR;
			end
			OPC_JALR: begin
				illegal = (funct3 != 3'b000);
				flags.jalr = 1'b1;
				flags.wr_reg = 1'b1;
				dpath.src_a_sel = SRC_A_PC;
				dpath.src_b_sel = SRC_B_FOUR;
			end
			OPC_MISC_MEM: begin
				// plain fence is a no-op in this in-order pipe
				if (funct3 == 3'b000) begin
					illegal = (inst_DX[31:28] != 4'd0) || (rs1_addr != '0) || (rd_addr != '0);
				end else if (funct3 == 3'b001) begin
					illegal = (funct12 != 12'd0) || (rs1_addr != '0) || (rd_addr != '0);
					flags.fence_i = !illegal;
				end else begin
					illegal = 1'b1;
				end
			end
			OPC_OP_IMM: begin
				flags.wr_reg = 1'b1;
				dpath.alu_op = alu_op_arith;
				if (funct3 == 3'b001)
					illegal = (funct7 != 7'd0);
				else if (funct3 == 3'b101)
					illegal = (funct7 != 7'd0) && (funct7 != 7'h20);
			end
			OPC_OP: begin
				flags.uses_rs2 = 1'b1;
				flags.wr_reg = 1'b1;
				dpath.src_b_sel = SRC_B_RS2;
				dpath.alu_op = alu_op_arith;
				if (funct7 == 7'h01) begin
					flags.uses_md = 1'b1;
					flags.wb_src_sel = WB_SRC_MD;
				end else if (funct7 == 7'h20) begin
					illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
				end else begin
					illegal = (funct7 != 7'd0);
				end
			end
			OPC_SYSTEM: begin
				flags.wb_src_sel = WB_SRC_CSR;
				flags.wr_reg = (funct3 != 3'b000);
				case (funct3)
					3'b000: begin
						illegal = (rs1_addr != '0) || (rd_addr != '0);
						if (funct12 == 12'h000)
							ecall = !illegal;
						else if (funct12 == 12'h001)
							ebreak = !illegal;
						else if (funct12 == 12'h100 && prv != '0)
							flags.eret = !illegal;
						else
							illegal = 1'b1;
					end
					3'b001, 3'b101: flags.csr_cmd = (rs1_addr == '0) ? CSR_READ : CSR_WRITE;
					3'b010, 3'b110: flags.csr_cmd = (rs1_addr == '0) ? CSR_READ : CSR_SET;
					3'b011, 3'b111: flags.csr_cmd = (rs1_addr == '0) ? CSR_READ : CSR_CLEAR;
					default: illegal = 1'b1;
				endcase
			end
			OPC_AUIPC: begin
				flags.uses_rs1 = 1'b0;
				flags.wr_reg = 1'b1;
				dpath.src_a_sel = SRC_A_PC;
				dpath.imm_type = IMM_U;
			end
			OPC_LUI: begin
				flags.uses_rs1 = 1'b0;
				flags.wr_reg = 1'b1;
				dpath.src_a_sel = SRC_A_ZERO;
				dpath.imm_type = IMM_U;
			end
			default: illegal = 1'b1;
		endcase

		// illegal wins over breakpoint, breakpoint over ecall
		flags.new_ex = illegal || ebreak || ecall;
		if (ebreak && !illegal)
			flags.new_ex_code = ECODE_BREAKPOINT;
		else if (ecall && !illegal)
			flags.new_ex_code = ecode_e'(4'(ECODE_ECALL_FROM_U) + 4'(prv));
	end

endmodule

// File: design/hazard_unit.sv
module hazard_unit import ctrl_pkg::*; (
	input dx_flags_t flags,
	input wb_state_t wb,
	input logic md_resp_valid,
	output logic bypass_rs1,
	output logic bypass_rs2,
	output logic hazard_stall
);

	logic raw_rs1;
	logic raw_rs2;
	logic load_use;
	logic raw_on_busy_md;

	// WB writes a register that DX reads, x0 never counts
	assign raw_rs1 = wb.wr_reg && flags.uses_rs1
		&& (flags.rs1_addr == wb.reg_to_wr) && (flags.rs1_addr != '0);
	assign raw_rs2 = wb.wr_reg && flags.uses_rs2
		&& (flags.rs2_addr == wb.reg_to_wr) && (flags.rs2_addr != '0);

	// load data arrives too late in WB to forward
	assign bypass_rs1 = raw_rs1 && !wb.load_in_wb;
	assign bypass_rs2 = raw_rs2 && !wb.load_in_wb;

	assign load_use = wb.load_in_wb && (raw_rs1 || raw_rs2);

	// md result not back yet
	assign raw_on_busy_md = wb.uses_md_wb && (raw_rs1 || raw_rs2) && !md_resp_valid;

	assign hazard_stall = load_use || raw_on_busy_md;

endmodule

// File: design/stage_ctrl.sv
`include "ctrl_settings.svh"

module stage_ctrl import ctrl_pkg::*; (
	input logic clk,
	input logic reset,
	input dx_flags_t flags,
	input logic hazard_stall,
	input logic imem_wait,
	input logic imem_badmem_e,
	input logic dmem_wait,
	input logic dmem_badmem_e,
	input logic md_req_ready,
	input logic md_resp_valid,
	input logic illegal_csr_access,
	output stage_ctrl_t stages,
	output wb_state_t wb_hazard,
	output wb_port_t wb,
	output pc_src_e pc_src_sel,
	output logic dmem_en,
	output logic dmem_wen,
	output logic md_req_valid,
	output logic eret,
	output csr_cmd_e csr_cmd,
	output logic exception_WB,
	output ecode_e exception_code_WB,
	output logic retire_WB
);

	logic replay_if;
	logic ex_if;
	logic stall_if;
	logic kill_if;
	logic had_ex_dx;
	logic prev_killed_dx;
	logic ex_dx;
	logic stall_dx;
	logic kill_dx;
	logic killed_dx;
	ecode_e ex_code_dx;
	logic branch_taken;
	logic jal;
	logic jalr;
	logic redirect;
	logic wr_reg_dx;
	logic prev_killed_wb;
	logic had_ex_wb;
	logic wr_reg_unkilled_wb;
	logic store_in_wb;
	logic dmem_en_wb;
	logic uses_md_wb;
	ecode_e prev_ex_code_wb;
	logic [`REG_ADDR_WIDTH-1:0] reg_to_wr_wb;
	wb_src_e wb_src_sel_wb;
	logic dmem_fault;
	logic ex_wb;
	logic stall_wb;
	logic kill_wb;

	// refetch after reset, after a redirect lost to imem_wait, or after fence.i
	always_ff @(posedge clk) begin
		if (reset) begin
			replay_if <= 1'b1;
		end else begin
			replay_if <= (redirect && imem_wait) || (flags.fence_i && store_in_wb);
		end
	end

	assign ex_if = imem_badmem_e && !imem_wait && !redirect && !replay_if;
	assign stall_if = stall_dx || (imem_wait && !redirect && !ex_wb);
	assign kill_if = stall_if || ex_if || ex_dx || ex_wb || redirect || replay_if;

	always_ff @(posedge clk) begin
		if (reset) begin
			had_ex_dx <= 1'b0;
			prev_killed_dx <= 1'b1;
		end else if (!stall_dx) begin
			had_ex_dx <= ex_if;
			prev_killed_dx <= kill_if;
		end
	end

	assign ex_dx = had_ex_dx || flags.new_ex || illegal_csr_access;
	assign stall_dx = stall_wb || ((hazard_stall || (flags.fence_i && store_in_wb)
		|| (flags.uses_md && !md_req_ready)) && !(ex_dx || ex_wb));
	assign kill_dx = stall_dx || ex_dx || ex_wb;
	assign killed_dx = prev_killed_dx || kill_dx;

	// a fetch fault carried from IF wins over anything decoded here
	always_comb begin
		if (had_ex_dx)
			ex_code_dx = ECODE_INST_ADDR_MISALIGNED;
		else if (flags.new_ex)
			ex_code_dx = flags.new_ex_code;
		else if (illegal_csr_access)
			ex_code_dx = ECODE_ILLEGAL_INST;
		else
			ex_code_dx = ECODE_INST_ADDR_MISALIGNED;
	end

	// nothing leaves DX unless the stage survives
	assign branch_taken = flags.branch_taken && !kill_dx;
	assign jal = flags.jal && !kill_dx;
	assign jalr = flags.jalr && !kill_dx;
	assign eret = flags.eret && !kill_dx;
	assign dmem_en = flags.dmem_en && !kill_dx;
	assign dmem_wen = flags.dmem_wen && !kill_dx;
	assign md_req_valid = flags.uses_md && !kill_dx;
	assign wr_reg_dx = flags.wr_reg && !kill_dx;
	assign csr_cmd = kill_dx ? CSR_IDLE : flags.csr_cmd;
	assign redirect = branch_taken || jal || jalr || eret;

	always_comb begin
		if (ex_wb)
			pc_src_sel = PC_HANDLER;
		else if (replay_if || (stall_if && !imem_wait))
			pc_src_sel = PC_REPLAY;
		else if (eret)
			pc_src_sel = PC_EPC;
		else if (branch_taken)
			pc_src_sel = PC_BRANCH_TARGET;
		else if (jal)
			pc_src_sel = PC_JAL_TARGET;
		else if (jalr)
			pc_src_sel = PC_JALR_TARGET;
		else
			pc_src_sel = PC_PLUS_FOUR;
	end

	// WB starts out as an empty bubble
	always_ff @(posedge clk) begin
		if (reset) begin
			prev_killed_wb <= 1'b1;
			had_ex_wb <= 1'b0;
			wr_reg_unkilled_wb <= 1'b0;
			store_in_wb <= 1'b0;
			dmem_en_wb <= 1'b0;
			uses_md_wb <= 1'b0;
		end else if (!stall_wb) begin
			prev_killed_wb <= killed_dx;
			had_ex_wb <= ex_dx;
			wr_reg_unkilled_wb <= wr_reg_dx;
			store_in_wb <= dmem_wen;
			dmem_en_wb <= dmem_en;
			uses_md_wb <= md_req_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_wb) begin
			prev_ex_code_wb <= ex_code_dx;
			reg_to_wr_wb <= flags.rd_addr;
			wb_src_sel_wb <= flags.wb_src_sel;
		end
	end

	assign dmem_fault = dmem_badmem_e && dmem_en_wb;
	assign ex_wb = had_ex_wb || dmem_fault;
	assign stall_wb = ((dmem_wait && dmem_en_wb) || (uses_md_wb && !md_resp_valid)) && !ex_wb;
	assign kill_wb = stall_wb || ex_wb;

	// a data fault on something that writes a register was a load
	always_comb begin
		if (!had_ex_wb && dmem_fault)
			exception_code_WB = wr_reg_unkilled_wb ? ECODE_LOAD_ADDR_MISALIGNED
				: ECODE_STORE_AMO_ADDR_MISALIGNED;
		else
			exception_code_WB = prev_ex_code_wb;
	end

	assign exception_WB = ex_wb;
	assign retire_WB = !(kill_wb || prev_killed_wb);

	assign wb.wr_reg = wr_reg_unkilled_wb && !kill_wb;
	assign wb.reg_to_wr = reg_to_wr_wb;
	assign wb.wb_src_sel = wb_src_sel_wb;

	assign wb_hazard.wr_reg = wb.wr_reg;
	assign wb_hazard.reg_to_wr = reg_to_wr_wb;
	assign wb_hazard.load_in_wb = dmem_en_wb && !store_in_wb;
	assign wb_hazard.uses_md_wb = uses_md_wb;

	assign stages.stall_if = stall_if;
	assign stages.kill_if = kill_if;
	assign stages.stall_dx = stall_dx;
	assign stages.kill_dx = kill_dx;
	assign stages.stall_wb = stall_wb;
	assign stages.kill_wb = kill_wb;

endmodule

// File: design/vscale_ctrl.sv
`include "ctrl_settings.svh"

module vscale_ctrl import ctrl_pkg::*; (
	input logic clk,
	input logic reset,
	input logic [`INST_WIDTH-1:0] inst_DX,
	input logic cmp_true,
	input logic [`PRV_WIDTH-1:0] prv,
	input logic imem_wait,
	input logic imem_badmem_e,
	input logic dmem_wait,
	input logic dmem_badmem_e,
	input logic md_req_ready,
	input logic md_resp_valid,
	input logic illegal_csr_access,
	output dpath_ctrl_t dpath,
	output pc_src_e pc_src_sel,
	output logic bypass_rs1,
	output logic bypass_rs2,
	output logic dmem_en,
	output logic dmem_wen,
	output logic md_req_valid,
	output csr_cmd_e csr_cmd,
	output logic eret,
	output wb_port_t wb,
	output stage_ctrl_t stages,
	output logic exception_WB,
	output ecode_e exception_code_WB,
	output logic retire_WB
);

	dx_flags_t flags;
	wb_state_t wb_hazard;
	logic hazard_stall;

	inst_decoder inst_decoder_i (
		.inst_DX  (inst_DX),
		.cmp_true (cmp_true),
		.prv      (prv),
		.dpath    (dpath),
		.flags    (flags)
	);

	hazard_unit hazard_unit_i (
		.flags         (flags),
		.wb            (wb_hazard),
		.md_resp_valid (md_resp_valid),
		.bypass_rs1    (bypass_rs1),
		.bypass_rs2    (bypass_rs2),
		.hazard_stall  (hazard_stall)
	);

	stage_ctrl stage_ctrl_i (
		.clk                (clk),
		.reset              (reset),
		.flags              (flags),
		.hazard_stall       (hazard_stall),
		.imem_wait          (imem_wait),
		.imem_badmem_e      (imem_badmem_e),
		.dmem_wait          (dmem_wait),
		.dmem_badmem_e      (dmem_badmem_e),
		.md_req_ready       (md_req_ready),
		.md_resp_valid      (md_resp_valid),
		.illegal_csr_access (illegal_csr_access),
		.stages             (stages),
		.wb_hazard          (wb_hazard),
		.wb                 (wb),
		.pc_src_sel         (pc_src_sel),
		.dmem_en            (dmem_en),
		.dmem_wen           (dmem_wen),
		.md_req_valid       (md_req_valid),
		.eret               (eret),
		.csr_cmd            (csr_cmd),
		.exception_WB       (exception_WB),
		.exception_code_WB  (exception_code_WB),
		.retire_WB          (retire_WB)
	);

endmodule

// File: testbench/ctrl_tb.sv
`include "ctrl_settings.svh"

module ctrl_tb import ctrl_pkg::*; ();

	localparam int PERIOD = 20;
	localparam int NUM_TESTS = 6;
	localparam int CYCLES_PER_TEST = 40;
	// addi x0, x0, 0
	localparam logic [31:0] NOP = 32'h0000_0013;

	logic clk = 1'b0;
	logic reset;
	logic [`INST_WIDTH-1:0] inst_DX;
	logic cmp_true;
	logic [`PRV_WIDTH-1:0] prv;
	logic imem_wait;
	logic imem_badmem_e;
	logic dmem_wait;
	logic dmem_badmem_e;
	logic md_req_ready;
	logic md_resp_valid;
	logic illegal_csr_access;
	dpath_ctrl_t dpath;
	pc_src_e pc_src_sel;
	logic bypass_rs1;
	logic bypass_rs2;
	logic dmem_en;
	logic dmem_wen;
	logic md_req_valid;
	csr_cmd_e csr_cmd;
	logic eret;
	wb_port_t wb;
	stage_ctrl_t stages;
	logic exception_WB;
	ecode_e exception_code_WB;
	logic retire_WB;

	int errors = 0;
	int errors_before = 0;
	int tests_done = 0;

	vscale_ctrl vscale_ctrl_i (.*);

	always #(PERIOD / 2) clk = ~clk;

	// instruction builders
	function automatic logic [31:0] r_type(input logic [6:0] funct7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] funct3, input logic [4:0] rd);
		return {funct7, rs2, rs1, funct3, rd, OPC_OP};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] funct3, input logic [4:0] rd, input opcode_e opc);
		return {imm, rs1, funct3, rd, opc};
	endfunction

	// sw with a small offset
	function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
	endfunction

	// branch offset fixed at +8
	function automatic logic [31:0] b_type(input logic [4:0] rs2, input logic [4:0] rs1,
		input logic [2:0] funct3);
		return {7'd0, rs2, rs1, funct3, 4'b0100, 1'b0, OPC_BRANCH};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
		input opcode_e opc);
		return {imm, rd, opc};
	endfunction

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_alu(input string name, input alu_op_e got, input alu_op_e exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_src_a(input string name, input src_a_e got, input src_a_e exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_pc(input string name, input pc_src_e got, input pc_src_e exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_ecode(input string name, input ecode_e got, input ecode_e exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_csr(input string name, input csr_cmd_e got, input csr_cmd_e exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_wb(input string name, input wb_port_t got, input wb_port_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic idle_inputs();
		inst_DX = NOP;
		cmp_true = 1'b0;
		prv = '0;
		imem_wait = 1'b0;
		imem_badmem_e = 1'b0;
		dmem_wait = 1'b0;
		dmem_badmem_e = 1'b0;
		md_req_ready = 1'b1;
		md_resp_valid = 1'b0;
		illegal_csr_access = 1'b0;
	endtask

	// inputs change 2 units after the edge
	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	// combinational outputs are stable well before the next edge
	task automatic settle();
		#5;
	endtask

	// two bubbles with md results accepted leave WB empty
	task automatic drain();
		idle_inputs();
		md_resp_valid = 1'b1;
		next_cycle();
		next_cycle();
		md_resp_valid = 1'b0;
	endtask

	task automatic finish_test(input string name);
		if (errors == errors_before)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - errors_before);
		errors_before = errors;
		tests_done++;
	endtask

	task automatic decode_step(input string name, input logic [31:0] inst, input alu_op_e alu,
		input src_a_e src_a, input logic mem_en, input logic mem_wen, input logic md_valid,
		input csr_cmd_e csr);
		inst_DX = inst;
		settle();
		check_alu({name, " dpath.alu_op"}, dpath.alu_op, alu);
		check_src_a({name, " dpath.src_a_sel"}, dpath.src_a_sel, src_a);
		check_bit({name, " dmem_en"}, dmem_en, mem_en);
		check_bit({name, " dmem_wen"}, dmem_wen, mem_wen);
		check_bit({name, " md_req_valid"}, md_req_valid, md_valid);
		check_csr({name, " csr_cmd"}, csr_cmd, csr);
	endtask

	task automatic test_decode();
		// one cycle of replay follows reset
		settle();
		check_bit("stages.kill_if", stages.kill_if, 1'b1);
		check_pc("pc_src_sel", pc_src_sel, PC_REPLAY);
		next_cycle();
		md_resp_valid = 1'b1;
		decode_step("add", r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), ALU_ADD, SRC_A_RS1,
			1'b0, 1'b0, 1'b0, CSR_IDLE);
		next_cycle();
		decode_step("sub", r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), ALU_SUB, SRC_A_RS1,
			1'b0, 1'b0, 1'b0, CSR_IDLE);
		next_cycle();
		decode_step("lui", u_type(20'h12345, 5'd6, OPC_LUI), ALU_ADD, SRC_A_ZERO,
			1'b0, 1'b0, 1'b0, CSR_IDLE);
		next_cycle();
		decode_step("auipc", u_type(20'h00010, 5'd7, OPC_AUIPC), ALU_ADD, SRC_A_PC,
			1'b0, 1'b0, 1'b0, CSR_IDLE);
		next_cycle();
		decode_step("blt", b_type(5'd2, 5'd1, 3'b100), ALU_SLT, SRC_A_RS1,
			1'b0, 1'b0, 1'b0, CSR_IDLE);
		check_pc("blt pc_src_sel", pc_src_sel, PC_PLUS_FOUR);
		next_cycle();
		decode_step("lw", i_type(12'd0, 5'd1, 3'b010, 5'd8, OPC_LOAD), ALU_ADD, SRC_A_RS1,
			1'b1, 1'b0, 1'b0, CSR_IDLE);
		next_cycle();
		decode_step("sw", s_type(12'd4, 5'd2, 5'd1), ALU_ADD, SRC_A_RS1,
			1'b1, 1'b1, 1'b0, CSR_IDLE);
		next_cycle();
		// md ops still pass funct3 through the arithmetic table
		decode_step("mulh", r_type(7'h01, 5'd2, 5'd1, 3'b001, 5'd9), ALU_SLL, SRC_A_RS1,
			1'b0, 1'b0, 1'b1, CSR_IDLE);
		check_bit("mulh dpath.md_in_1_signed", dpath.md_in_1_signed, 1'b1);
		check_bit("mulh dpath.md_in_2_signed", dpath.md_in_2_signed, 1'b1);
		next_cycle();
		decode_step("divu", r_type(7'h01, 5'd2, 5'd1, 3'b101, 5'd10), ALU_SRL, SRC_A_RS1,
			1'b0, 1'b0, 1'b1, CSR_IDLE);
		check_bit("divu dpath.md_in_1_signed", dpath.md_in_1_signed, 1'b0);
		check_bit("divu dpath.md_in_2_signed", dpath.md_in_2_signed, 1'b0);
		next_cycle();
		decode_step("csrrs x0", i_type(12'h300, 5'd0, 3'b010, 5'd11, OPC_SYSTEM), ALU_ADD,
			SRC_A_RS1, 1'b0, 1'b0, 1'b0, CSR_READ);
		next_cycle();
		decode_step("csrrs x5", i_type(12'h300, 5'd5, 3'b010, 5'd12, OPC_SYSTEM), ALU_ADD,
			SRC_A_RS1, 1'b0, 1'b0, 1'b0, CSR_SET);
		drain();
		finish_test("decode table");
	endtask

	task automatic test_exceptions();
		inst_DX = 32'h0000_007f;
		settle();
		check_bit("stages.kill_dx", stages.kill_dx, 1'b1);
		next_cycle();
		inst_DX = NOP;
		settle();
		check_bit("exception_WB", exception_WB, 1'b1);
		check_ecode("exception_code_WB", exception_code_WB, ECODE_ILLEGAL_INST);
		check_pc("pc_src_sel", pc_src_sel, PC_HANDLER);
		check_bit("retire_WB", retire_WB, 1'b0);
		check_bit("stages.kill_wb", stages.kill_wb, 1'b1);
		next_cycle();
		// ecall from machine mode
		prv = 2'd3;
		inst_DX = 32'h0000_0073;
		settle();
		check_bit("ecall stages.kill_dx", stages.kill_dx, 1'b1);
		next_cycle();
		inst_DX = NOP;
		settle();
		check_bit("ecall exception_WB", exception_WB, 1'b1);
		check_ecode("ecall exception_code_WB", exception_code_WB, ecode_e'(4'd11));
		drain();
		// eret from machine mode returns through the epc
		prv = 2'd3;
		inst_DX = 32'h1000_0073;
		settle();
		check_bit("eret", eret, 1'b1);
		check_pc("eret pc_src_sel", pc_src_sel, PC_EPC);
		drain();
		finish_test("exceptions");
	endtask

	task automatic test_bypass();
		wb_port_t exp_wb;
		inst_DX = i_type(12'd1, 5'd0, 3'b000, 5'd5, OPC_OP_IMM);
		next_cycle();
		inst_DX = r_type(7'h00, 5'd0, 5'd5, 3'b000, 5'd6);
		settle();
		exp_wb.wr_reg = 1'b1;
		exp_wb.reg_to_wr = 5'd5;
		exp_wb.wb_src_sel = WB_SRC_ALU;
		check_wb("wb", wb, exp_wb);
		check_bit("bypass_rs1", bypass_rs1, 1'b1);
		check_bit("bypass_rs2", bypass_rs2, 1'b0);
		check_bit("stages.stall_dx", stages.stall_dx, 1'b0);
		next_cycle();
		inst_DX = i_type(12'd5, 5'd0, 3'b000, 5'd0, OPC_OP_IMM);
		next_cycle();
		inst_DX = r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd7);
		settle();
		check_bit("x0 bypass_rs1", bypass_rs1, 1'b0);
		check_bit("x0 bypass_rs2", bypass_rs2, 1'b0);
		check_bit("x0 stages.stall_dx", stages.stall_dx, 1'b0);
		drain();
		finish_test("bypass");
	endtask

	task automatic test_load_use();
		inst_DX = i_type(12'd0, 5'd1, 3'b010, 5'd5, OPC_LOAD);
		next_cycle();
		inst_DX = r_type(7'h00, 5'd2, 5'd5, 3'b000, 5'd6);
		settle();
		check_bit("stages.stall_dx", stages.stall_dx, 1'b1);
		check_bit("bypass_rs1", bypass_rs1, 1'b0);
		next_cycle();
		// a bubble reaches WB, so the held instruction goes
		settle();
		check_bit("released stages.stall_dx", stages.stall_dx, 1'b0);
		next_cycle();
		inst_DX = b_type(5'd2, 5'd1, 3'b000);
		cmp_true = 1'b1;
		settle();
		check_pc("beq pc_src_sel", pc_src_sel, PC_BRANCH_TARGET);
		check_bit("beq stages.kill_if", stages.kill_if, 1'b1);
		drain();
		finish_test("load-use");
	endtask

	task automatic test_mul_div();
		md_req_ready = 1'b0;
		inst_DX = r_type(7'h01, 5'd2, 5'd1, 3'b000, 5'd9);
		settle();
		check_bit("stages.stall_dx", stages.stall_dx, 1'b1);
		check_bit("md_req_valid", md_req_valid, 1'b0);
		next_cycle();
		md_req_ready = 1'b1;
		settle();
		check_bit("ready stages.stall_dx", stages.stall_dx, 1'b0);
		check_bit("ready md_req_valid", md_req_valid, 1'b1);
		next_cycle();
		inst_DX = NOP;
		// result still pending for a few cycles
		repeat (3) begin
			settle();
			check_bit("busy stages.stall_wb", stages.stall_wb, 1'b1);
			next_cycle();
		end
		md_resp_valid = 1'b1;
		settle();
		check_bit("done stages.stall_wb", stages.stall_wb, 1'b0);
		check_bit("done retire_WB", retire_WB, 1'b1);
		drain();
		finish_test("multiply/divide");
	endtask

	task automatic test_mem_wb();
		inst_DX = i_type(12'd0, 5'd1, 3'b010, 5'd8, OPC_LOAD);
		next_cycle();
		inst_DX = NOP;
		dmem_wait = 1'b1;
		repeat (2) begin
			settle();
			check_bit("wait stages.stall_wb", stages.stall_wb, 1'b1);
			check_bit("wait stages.stall_if", stages.stall_if, 1'b1);
			next_cycle();
		end
		dmem_wait = 1'b0;
		settle();
		check_bit("ready stages.stall_wb", stages.stall_wb, 1'b0);
		drain();
		inst_DX = i_type(12'd0, 5'd1, 3'b010, 5'd8, OPC_LOAD);
		next_cycle();
		inst_DX = NOP;
		dmem_badmem_e = 1'b1;
		settle();
		check_bit("load exception_WB", exception_WB, 1'b1);
		check_ecode("load exception_code_WB", exception_code_WB, ECODE_LOAD_ADDR_MISALIGNED);
		next_cycle();
		dmem_badmem_e = 1'b0;
		inst_DX = s_type(12'd4, 5'd2, 5'd1);
		next_cycle();
		inst_DX = NOP;
		dmem_badmem_e = 1'b1;
		settle();
		check_bit("store exception_WB", exception_WB, 1'b1);
		check_ecode("store exception_code_WB", exception_code_WB,
			ECODE_STORE_AMO_ADDR_MISALIGNED);
		drain();
		finish_test("memory in WB");
	endtask

	initial begin
		#(NUM_TESTS * CYCLES_PER_TEST * PERIOD);
		$display("watchdog expired before the tests finished");
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		idle_inputs();
		reset = 1'b1;
		repeat (3) @(posedge clk);
		#2;
		reset = 1'b0;
		test_decode();
		test_exceptions();
		test_bypass();
		test_load_use();
		test_mul_div();
		test_mem_wb();
		$display("%0d tests run, %0d errors", tests_done, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+design
design/ctrl_pkg.sv
design/inst_decoder.sv
design/hazard_unit.sv
design/stage_ctrl.sv
design/vscale_ctrl.sv
testbench/ctrl_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --top-module ctrl_tb -f filelist.f -o ctrl_sim
./obj_dir/ctrl_sim | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
echo "simulation finished without failures"
